// File: logic/neo_dl_pkg.sv
`default_nettype none

package neo_dl_pkg;

	// Cart regions in file order
	typedef enum logic [2:0] {
		REG_P,
		REG_S,
		REG_M,
		REG_V1,
		REG_V2,
		REG_C,
		REG_DONE
	} region_t;

	typedef logic [26:0] ioctl_addr_t;
	typedef logic [31:0] rom_size_t;     // Region size in bytes
	typedef logic [15:0] sdr_word_t;
	typedef logic [22:0] bank3_addr_t;   // Port 1 word address
	typedef logic [24:0] bank012_addr_t; // Port 2 word address
	typedef logic [5:0]  page_idx_t;     // Word within a page

	// NEO file header
	localparam int HEADER_BYTES = 4096;
	localparam int SIZE_FIELD_FIRST = 4;
	localparam int SIZE_FIELD_LAST = 27;

	localparam int PAGE_BYTES = 128;

	localparam logic [7:0] CART_INDEX = 8'd1;

	// Bank 3 layout
	localparam logic [4:0] FIX_PREFIX = 5'b11100;
	localparam logic [4:0] MROM_PREFIX = 5'b11110;

endpackage

`default_nettype wire

// File: logic/neo_header_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module neo_header_tracker (
	input  wire                          CLK_48M,
	input  wire                          pll_locked,
	input  wire                          ioctl_downl,
	input  wire [7:0]                    ioctl_index,
	input  wire                          ioctl_wr,
	input  wire neo_dl_pkg::ioctl_addr_t ioctl_addr,
	input  wire [7:0]                    ioctl_dout,
	output logic                         cart_write,
	output logic                         in_header,
	output neo_dl_pkg::region_t          cur_region,
	output neo_dl_pkg::rom_size_t        c_size,
	output neo_dl_pkg::rom_size_t        v1_size
);

	neo_dl_pkg::rom_size_t   p_size;
	neo_dl_pkg::rom_size_t   s_size;
	neo_dl_pkg::rom_size_t   m_size;
	neo_dl_pkg::rom_size_t   v2_size;
	neo_dl_pkg::rom_size_t   region_size;
	neo_dl_pkg::ioctl_addr_t offset;   // Byte offset inside cur_region
	logic                    inc_pend;
	logic                    chk_pend;
	logic                    size_byte;
	logic                    header_last;

	assign cart_write = ioctl_downl && ioctl_index == neo_dl_pkg::CART_INDEX;
	assign in_header = ioctl_addr < neo_dl_pkg::HEADER_BYTES;
	assign size_byte = ioctl_addr >= neo_dl_pkg::SIZE_FIELD_FIRST &&
		ioctl_addr <= neo_dl_pkg::SIZE_FIELD_LAST;
	assign header_last = ioctl_addr == neo_dl_pkg::HEADER_BYTES - 1;

	always_comb begin
		case (cur_region)
			neo_dl_pkg::REG_P:  region_size = p_size;
			neo_dl_pkg::REG_S:  region_size = s_size;
			neo_dl_pkg::REG_M:  region_size = m_size;
			neo_dl_pkg::REG_V1: region_size = v1_size;
			neo_dl_pkg::REG_V2: region_size = v2_size;
			neo_dl_pkg::REG_C:  region_size = c_size;
			default:            region_size = '0;
		endcase
	end

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			cur_region <= neo_dl_pkg::REG_P;
			offset <= '0;
			inc_pend <= 1'b0;
			chk_pend <= 1'b0;
			p_size <= '0;
			s_size <= '0;
			m_size <= '0;
			v1_size <= '0;
			v2_size <= '0;
			c_size <= '0;
		end else begin
			inc_pend <= 1'b0;

			if (inc_pend) begin
				offset <= offset + 1'd1;
				chk_pend <= 1'b1;
			end else if (chk_pend) begin
				// One region per cycle, so empty regions fall through
				if ({5'd0, offset} == region_size) begin
					offset <= '0;
					cur_region <= neo_dl_pkg::region_t'(cur_region + 3'd1);
					chk_pend <= cur_region != neo_dl_pkg::REG_C;
				end else begin
					chk_pend <= 1'b0;
				end
			end

			if (ioctl_wr && cart_write) begin
				if (in_header) begin
					cur_region <= neo_dl_pkg::REG_P;
					offset <= '0;
					chk_pend <= header_last; // Skips an empty P region
					if (size_byte) begin
						// Little endian, P first
						{c_size, v2_size, v1_size, m_size, s_size, p_size} <=
							{ioctl_dout, c_size, v2_size, v1_size, m_size, s_size, p_size[31:8]};
					end
				end else if (cur_region != neo_dl_pkg::REG_DONE) begin
					inc_pend <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/neo_page_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module neo_page_buffer (
	input  wire                          CLK_48M,
	input  wire                          pll_locked,
	input  wire                          cart_write,
	input  wire                          in_header,
	input  wire neo_dl_pkg::region_t     cur_region,
	input  wire                          ioctl_wr,
	input  wire neo_dl_pkg::ioctl_addr_t ioctl_addr,
	input  wire [7:0]                    ioctl_dout,
	input  wire neo_dl_pkg::page_idx_t   rd_idx,
	input  wire                          drain_busy,
	output logic                         page_ready,
	output neo_dl_pkg::region_t          page_region,
	output neo_dl_pkg::sdr_word_t        rd_word
);

	// Two pages of 64 words, byte writable
	logic [1:0][7:0] mem [neo_dl_pkg::PAGE_BYTES];
	logic            fill_page;
	logic [6:0]      wr_pos;
	logic            data_wr;
	logic            page_last;

	assign data_wr = ioctl_wr && cart_write && !in_header &&
		cur_region != neo_dl_pkg::REG_DONE;
	assign page_last = &ioctl_addr[6:0];

	// Tile fetcher byte order for fix and sprite data
	always_comb begin
		case (cur_region)
			neo_dl_pkg::REG_S:
				wr_pos = {ioctl_addr[6:5], ioctl_addr[2:0], ~ioctl_addr[4], ioctl_addr[3]};
			neo_dl_pkg::REG_C:
				wr_pos = {ioctl_addr[5:2], ~ioctl_addr[6], ioctl_addr[0], ioctl_addr[1]};
			default:
				wr_pos = ioctl_addr[6:0];
		endcase
	end

	always_ff @(posedge CLK_48M) begin
		if (data_wr) begin
			mem[{fill_page, wr_pos[6:1]}][wr_pos[0]] <= ioctl_dout;
		end
		if (drain_busy) begin
			rd_word <= mem[{~fill_page, rd_idx}]; // Drain side reads the other page
		end
	end

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			fill_page <= 1'b0;
			page_ready <= 1'b0;
			page_region <= neo_dl_pkg::REG_P;
		end else begin
			page_ready <= 1'b0;
			if (data_wr && page_last) begin
				fill_page <= ~fill_page;
				page_region <= cur_region;
				page_ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/neo_sdram_writer.sv
`timescale 1ns/10ps
`default_nettype none

module neo_sdram_writer (
	input  wire                            CLK_48M,
	input  wire                            pll_locked,
	input  wire                            page_ready,
	input  wire neo_dl_pkg::region_t       page_region,
	input  wire neo_dl_pkg::sdr_word_t     rd_word,
	input  wire neo_dl_pkg::rom_size_t     c_size,
	input  wire neo_dl_pkg::rom_size_t     v1_size,
	input  wire                            port1_ack,
	input  wire                            port2_ack,
	output neo_dl_pkg::page_idx_t          rd_idx,
	output logic                           drain_busy,
	output logic                           port1_req,
	output neo_dl_pkg::bank3_addr_t        port1_a,
	output neo_dl_pkg::sdr_word_t          port1_d,
	output logic                           port2_req,
	output neo_dl_pkg::bank012_addr_t      port2_a,
	output neo_dl_pkg::sdr_word_t          port2_d
);

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_ISSUE, ST_WAIT} state_t;

	state_t                  state;
	neo_dl_pkg::region_t     wr_region;
	neo_dl_pkg::ioctl_addr_t offset;   // Byte offset within wr_region
	logic                    to_port1;
	logic [23:0]             p1_byte;
	neo_dl_pkg::rom_size_t   p2_byte;
	logic                    acked;

	// Bank 0-2 holds C, then V1, then V2
	always_comb begin
		to_port1 = 1'b1;
		p1_byte = offset[23:0];
		p2_byte = {5'd0, offset};
		case (wr_region)
			neo_dl_pkg::REG_P: ;
			neo_dl_pkg::REG_S: p1_byte = {neo_dl_pkg::FIX_PREFIX, offset[18:0]};
			neo_dl_pkg::REG_M: p1_byte = {neo_dl_pkg::MROM_PREFIX, offset[18:0]};
			neo_dl_pkg::REG_V1: begin
				to_port1 = 1'b0;
				p2_byte = c_size + {5'd0, offset};
			end
			neo_dl_pkg::REG_V2: begin
				to_port1 = 1'b0;
				p2_byte = c_size + v1_size + {5'd0, offset};
			end
			default: to_port1 = 1'b0;
		endcase
	end

	assign acked = to_port1 ? port1_req == port1_ack : port2_req == port2_ack;
	assign drain_busy = state != ST_IDLE;

	always_ff @(posedge CLK_48M or negedge pll_locked) begin
		if (!pll_locked) begin
			state <= ST_IDLE;
			wr_region <= neo_dl_pkg::REG_P;
			offset <= '0;
			rd_idx <= '0;
			port1_req <= 1'b0;
			port2_req <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (page_ready) begin
					wr_region <= page_region;
					if (page_region != wr_region) offset <= '0; // New region starts at 0
					rd_idx <= '0;
					state <= ST_READ;
				end
				ST_READ: state <= ST_ISSUE; // rd_word lands here
				ST_ISSUE: begin
					if (to_port1) port1_req <= ~port1_req;
					else port2_req <= ~port2_req;
					state <= ST_WAIT;
				end
				ST_WAIT: if (acked) begin
					offset <= offset + 2'd2;
					rd_idx <= rd_idx + 1'd1;
					state <= &rd_idx ? ST_IDLE : ST_READ;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Held until the acknowledge
	always_ff @(posedge CLK_48M) begin
		if (state == ST_ISSUE) begin
			if (to_port1) begin
				port1_a <= p1_byte[23:1];
				port1_d <= rd_word;
			end else begin
				port2_a <= p2_byte[25:1];
				port2_d <= rd_word;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/neo_cart_loader.sv
`timescale 1ns/10ps
`default_nettype none

module neo_cart_loader (
	input  wire                            CLK_48M,
	input  wire                            pll_locked,

	input  wire                            ioctl_downl,
	input  wire [7:0]                      ioctl_index,
	input  wire                            ioctl_wr,
	input  wire neo_dl_pkg::ioctl_addr_t   ioctl_addr,
	input  wire [7:0]                      ioctl_dout,

	output wire                            port1_req,
	input  wire                            port1_ack,
	output wire neo_dl_pkg::bank3_addr_t   port1_a,
	output wire neo_dl_pkg::sdr_word_t     port1_d,

	output wire                            port2_req,
	input  wire                            port2_ack,
	output wire neo_dl_pkg::bank012_addr_t port2_a,
	output wire neo_dl_pkg::sdr_word_t     port2_d
);

	wire                        cart_write;
	wire                        in_header;
	wire neo_dl_pkg::region_t   cur_region;
	wire neo_dl_pkg::rom_size_t c_size;
	wire neo_dl_pkg::rom_size_t v1_size;

	wire                        page_ready;
	wire neo_dl_pkg::region_t   page_region;
	wire neo_dl_pkg::sdr_word_t rd_word;
	wire neo_dl_pkg::page_idx_t rd_idx;
	wire                        drain_busy;

	neo_header_tracker i_header_tracker (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.ioctl_downl (ioctl_downl),
		.ioctl_index (ioctl_index),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.cart_write  (cart_write),
		.in_header   (in_header),
		.cur_region  (cur_region),
		.c_size      (c_size),
		.v1_size     (v1_size)
	);

	neo_page_buffer i_page_buffer (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.cart_write  (cart_write),
		.in_header   (in_header),
		.cur_region  (cur_region),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.rd_idx      (rd_idx),
		.drain_busy  (drain_busy),
		.page_ready  (page_ready),
		.page_region (page_region),
		.rd_word     (rd_word)
	);

	neo_sdram_writer i_sdram_writer (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.page_ready  (page_ready),
		.page_region (page_region),
		.rd_word     (rd_word),
		.c_size      (c_size),
		.v1_size     (v1_size),
		.port1_ack   (port1_ack),
		.port2_ack   (port2_ack),
		.rd_idx      (rd_idx),
		.drain_busy  (drain_busy),
		.port1_req   (port1_req),
		.port1_a     (port1_a),
		.port1_d     (port1_d),
		.port2_req   (port2_req),
		.port2_a     (port2_a),
		.port2_d     (port2_d)
	);

endmodule

`default_nettype wire

// File: bench/neo_cart_loader_sva.sv
`timescale 1ns/10ps
`default_nettype none

module neo_cart_loader_sva (
	input wire                            CLK_48M,
	input wire                            pll_locked,
	input wire                            port1_req,
	input wire                            port1_ack,
	input wire neo_dl_pkg::bank3_addr_t   port1_a,
	input wire neo_dl_pkg::sdr_word_t     port1_d,
	input wire                            port2_req,
	input wire                            port2_ack,
	input wire neo_dl_pkg::bank012_addr_t port2_a,
	input wire neo_dl_pkg::sdr_word_t     port2_d
);

	int  assert_fails = 0;  // Read by the testbench
	wire p1_pend;
	wire p2_pend;

	assign p1_pend = port1_req != port1_ack;
	assign p2_pend = port2_req != port2_ack;

	// New request only with both ports idle
	p1_toggle_idle: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		$changed(port1_req) |-> $past(!p1_pend && !p2_pend))
		else begin
			assert_fails++;
			$error("port 1 request toggled while a write was pending");
		end

	p2_toggle_idle: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		$changed(port2_req) |-> $past(!p1_pend && !p2_pend))
		else begin
			assert_fails++;
			$error("port 2 request toggled while a write was pending");
		end

	p1_hold: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		p1_pend |=> $stable(port1_a) && $stable(port1_d))
		else begin
			assert_fails++;
			$error("port 1 address or data changed before the acknowledge");
		end

	p2_hold: assert property (@(posedge CLK_48M) disable iff (!pll_locked)
		p2_pend |=> $stable(port2_a) && $stable(port2_d))
		else begin
			assert_fails++;
			$error("port 2 address or data changed before the acknowledge");
		end

endmodule

bind neo_sdram_writer neo_cart_loader_sva i_handshake_sva (
	.CLK_48M    (CLK_48M),
	.pll_locked (pll_locked),
	.port1_req  (port1_req),
	.port1_ack  (port1_ack),
	.port1_a    (port1_a),
	.port1_d    (port1_d),
	.port2_req  (port2_req),
	.port2_ack  (port2_ack),
	.port2_a    (port2_a),
	.port2_d    (port2_d)
);

`default_nettype wire

// File: bench/tb_neo_cart_loader.sv
`timescale 1ns/10ps
`default_nettype none

module tb_neo_cart_loader;

	localparam int NUM_CARTS = 3;
	localparam int HEADER_LEN = 4096;
	localparam int MAX_DATA = 6 * 512;
	localparam int CART_CYCLES = (HEADER_LEN + MAX_DATA) * 12 + 4000;
	localparam int CYCLE_LIMIT = NUM_CARTS * CART_CYCLES;
	localparam logic [4:0] FIX_PFX = 5'b11100;
	localparam logic [4:0] MROM_PFX = 5'b11110;

	// Region numbers in file order
	localparam int R_P = 0;
	localparam int R_S = 1;
	localparam int R_M = 2;
	localparam int R_V1 = 3;
	localparam int R_V2 = 4;
	localparam int R_C = 5;

	logic        CLK_48M;
	logic        pll_locked;
	logic        ioctl_downl;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [26:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        port1_req;
	logic        port1_ack;
	logic [22:0] port1_a;
	logic [15:0] port1_d;
	logic        port2_req;
	logic        port2_ack;
	logic [24:0] port2_a;
	logic [15:0] port2_d;

	integer      seed = 32'h23ae;
	int          sizes [6];
	logic [7:0]  image [HEADER_LEN + MAX_DATA];
	logic [41:0] exp_q [$];  // {on port 2, word address, data}
	int          data_bytes = 0;
	int          writes_cart = 0;
	int          writes_total = 0;
	int          cycles = 0;
	int          value_errs = 0;
	int          proto_errs = 0;
	int          timeouts = 0;
	logic        p1_seen = 1'b0;
	logic        p2_seen = 1'b0;
	int          p1_delay = 0;
	int          p2_delay = 0;

	neo_cart_loader i_neo_cart_loader (
		.CLK_48M     (CLK_48M),
		.pll_locked  (pll_locked),
		.ioctl_downl (ioctl_downl),
		.ioctl_index (ioctl_index),
		.ioctl_wr    (ioctl_wr),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.port1_req   (port1_req),
		.port1_ack   (port1_ack),
		.port1_a     (port1_a),
		.port1_d     (port1_d),
		.port2_req   (port2_req),
		.port2_ack   (port2_ack),
		.port2_a     (port2_a),
		.port2_d     (port2_d)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #4 CLK_48M = ~CLK_48M;
	end

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed);
		return lo + ((r & 32'h7fffffff) % (hi - lo + 1));
	endfunction

	// Position of a page byte in the tile fetcher layout
	function automatic logic [6:0] shuffle_pos(input int r, input logic [6:0] a);
		if (r == R_S)
			return {a[6:5], a[2:0], ~a[4], a[3]};
		else if (r == R_C)
			return {a[5:2], ~a[6], a[0], a[1]};
		return a;
	endfunction

	function automatic logic [24:0] word_addr(input int r, input int off);
		logic [25:0] byte_a;
		logic [31:0] o;
		o = off;
		case (r)
			R_S: byte_a = {2'b00, FIX_PFX, o[18:0]};
			R_M: byte_a = {2'b00, MROM_PFX, o[18:0]};
			R_V1: byte_a = 26'(sizes[R_C] + off);  // C sits below V1
			R_V2: byte_a = 26'(sizes[R_C] + sizes[R_V1] + off);
			default: byte_a = o[25:0];
		endcase
		return byte_a[25:1];
	endfunction

	task automatic make_cart(input int cart);
		int r;
		int i;
		for (r = 0; r < 6; r++) begin
			sizes[r] = 128 * rand_range(1, 4);
		end
		if (cart % 2 == 1) sizes[R_V2] = 0;
		for (i = 0; i < HEADER_LEN + MAX_DATA; i++) begin
			image[i] = 8'(rand_range(0, 255));
		end
		for (r = 0; r < 6; r++) begin
			for (i = 0; i < 4; i++) begin
				image[4 + 4 * r + i] = 8'(sizes[r] >> (8 * i)); // Little endian
			end
		end
	endtask

	task automatic build_expected();
		logic [7:0] page [128];
		logic       on_port2;
		int         base;
		int         r;
		int         pg;
		int         b;
		base = HEADER_LEN;
		for (r = 0; r < 6; r++) begin
			on_port2 = r >= R_V1;
			for (pg = 0; pg < sizes[r] / 128; pg++) begin
				for (b = 0; b < 128; b++) begin
					page[shuffle_pos(r, 7'(b))] = image[base + pg * 128 + b];
				end
				for (b = 0; b < 64; b++) begin
					exp_q.push_back({on_port2, word_addr(r, pg * 128 + 2 * b),
						page[2 * b + 1], page[2 * b]});
				end
			end
			base += sizes[r];
		end
	endtask

	task automatic send_byte(input int a, input logic [7:0] d, input int gap);
		@(posedge CLK_48M);
		ioctl_addr <= 27'(a);
		ioctl_dout <= d;
		ioctl_wr <= 1'b1;
		@(posedge CLK_48M);
		ioctl_wr <= 1'b0;
		repeat (gap - 2) @(posedge CLK_48M);
	endtask

	task automatic check_write(input logic on_port2, input logic [24:0] addr,
		input logic [15:0] data);
		logic [41:0] exp;
		assert (writes_cart < (data_bytes / 128) * 64) else begin
			proto_errs++;
			$display("Write on port %0d at %0t came before its data page was complete",
				on_port2 ? 2 : 1, $time);
		end
		assert (exp_q.size() != 0) else begin
			proto_errs++;
			$display("Unexpected write on port %0d at %0t to address %h",
				on_port2 ? 2 : 1, $time, addr);
		end
		if (exp_q.size() != 0) begin
			exp = exp_q.pop_front();
			assert ({on_port2, addr, data} == exp) else begin
				value_errs++;
				$display("FAIL %0t: write %0d port %0d addr %h data %h, expected %0d %h %h",
					$time, writes_total, on_port2 ? 2 : 1, addr, data,
					exp[41] ? 2 : 1, exp[40:16], exp[15:0]);
			end
		end
		writes_cart++;
		writes_total++;
	endtask

	task automatic finish_run();
		int total;
		int sva_fails;
		sva_fails = i_neo_cart_loader.i_sdram_writer.i_handshake_sva.assert_fails;
		total = value_errs + proto_errs + timeouts + sva_fails;
		$display("%0d writes, errors: %0d value, %0d protocol, %0d assertion, %0d timeout",
			writes_total, value_errs, proto_errs, sva_fails, timeouts);
		if (total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	// SDRAM models, requests seen at the falling edge
	always @(negedge CLK_48M) begin
		if (port1_req !== p1_seen) begin
			p1_seen = port1_req;
			check_write(1'b0, {2'b00, port1_a}, port1_d);
			p1_delay = rand_range(1, 8);
		end
		if (port2_req !== p2_seen) begin
			p2_seen = port2_req;
			check_write(1'b1, port2_a, port2_d);
			p2_delay = rand_range(1, 8);
		end
	end

	always @(posedge CLK_48M) begin
		if (p1_delay > 0) begin
			p1_delay = p1_delay - 1;
			if (p1_delay == 0) port1_ack <= p1_seen;
		end
		if (p2_delay > 0) begin
			p2_delay = p2_delay - 1;
			if (p2_delay == 0) port2_ack <= p2_seen;
		end
	end

	always @(posedge CLK_48M) begin
		cycles++;
		if (cycles == CYCLE_LIMIT) begin
			timeouts++;
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			finish_run();
		end
	end

	initial begin
		int cart;
		int a;
		int data_len;
		pll_locked = 1'b0;
		ioctl_downl = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		port1_ack = 1'b0;
		port2_ack = 1'b0;
		repeat (10) @(posedge CLK_48M);
		pll_locked <= 1'b1;
		repeat (5) @(posedge CLK_48M);

		for (cart = 0; cart < NUM_CARTS; cart++) begin
			make_cart(cart);
			build_expected();
			data_len = sizes[R_P] + sizes[R_S] + sizes[R_M] + sizes[R_V1] + sizes[R_V2] +
				sizes[R_C];
			data_bytes = 0;
			writes_cart = 0;
			@(posedge CLK_48M);
			ioctl_index <= 8'd1;
			ioctl_downl <= 1'b1;
			for (a = 0; a < HEADER_LEN + data_len; a++) begin
				if (a >= HEADER_LEN) data_bytes++;
				send_byte(a, image[a], rand_range(4, 10));
			end
			ioctl_downl <= 1'b0;
			while (exp_q.size() != 0) @(posedge CLK_48M);
			repeat (200) @(posedge CLK_48M);  // Catch stray writes
			assert (writes_cart == data_len / 2) else begin
				value_errs++;
				$display("FAIL %0t: cart %0d gave %0d writes, expected %0d",
					$time, cart, writes_cart, data_len / 2);
			end
		end
		finish_run();
	end

endmodule

`default_nettype wire

// File: project.f
logic/neo_dl_pkg.sv
logic/neo_header_tracker.sv
logic/neo_page_buffer.sv
logic/neo_sdram_writer.sv
logic/neo_cart_loader.sv
bench/neo_cart_loader_sva.sv
bench/tb_neo_cart_loader.sv
